/* verilog/pe_params.svh */
/* fixed sizes of the row-stationary PE, no per-instance override
   filter_len * filter_num must fit the weight pad */
`ifndef PE_PARAMS_SVH
`define PE_PARAMS_SVH

// ------------------------------
// datapath widths
// ------------------------------
`define PE_DATA_W 16 // pixel and weight, signed
`define PE_PSUM_W 40 // 2 x 16 product plus growth over 64 products

// ------------------------------
// pad sizes
// ------------------------------
`define PE_W_PAD_SIZE 64 // weight pad entries

// window slots, also the largest filter_len
`define PE_IF_PAD_SIZE 8

`define PE_MAX_FILTERS 8 // largest filter_num

`endif

/* verilog/pe_pkg.sv */
/* types shared by the PE blocks, widths follow pe_params.svh
   tap and filter counts carry one extra bit to hold the full count */
`default_nettype none

`include "pe_params.svh"

package pe_pkg;

  // ------------------------------
  // vectors
  // ------------------------------
  typedef logic signed [`PE_DATA_W-1:0] data_t; // pixel / weight
  typedef logic signed [`PE_PSUM_W-1:0] psum_t; // accumulator / result

  typedef logic [$clog2(`PE_W_PAD_SIZE)-1:0] waddr_t; // weight pad address
  typedef logic [$clog2(`PE_IF_PAD_SIZE)-1:0] faddr_t; // window slot

  typedef logic [$clog2(`PE_IF_PAD_SIZE):0] tap_cnt_t; // 1..8 taps
  typedef logic [$clog2(`PE_MAX_FILTERS):0] filt_idx_t; // filter index or count

  // ------------------------------
  // structs
  // ------------------------------
  typedef struct packed {
    tap_cnt_t  filter_len; // taps per filter
    filt_idx_t filter_num; // filters per window
  } pe_cfg_t;

  // one result on the psum stream
  typedef struct packed {
    psum_t     psum;
    filt_idx_t filt;      // filter of this dot product
    logic      last_filt; // final filter of the window
  } pe_beat_t;

  typedef enum logic [1:0] {
    IDLE,  // wait for weights and a full window
    ACCUM, // one product per cycle
    DRAIN  // sum done, waiting for the output register
  } mac_state_t;

endpackage

`default_nettype wire

/* verilog/pe_weight_pad.sv */
/* weights load once after reset, filter by filter, oldest tap first
   needs filter_len * filter_num <= PE_W_PAD_SIZE, cfg stable during the run */
`default_nettype none

`include "pe_params.svh"

module pe_weight_pad import pe_pkg::*; (
  input  wire       clk,
  input  wire       rst,
  input  pe_cfg_t   cfg,
  // weight stream
  input  wire       weight_valid,
  output logic      weight_ready,
  input  data_t     weight,
  output logic      weights_loaded,
  // read port, async
  input  waddr_t    w_addr,
  output data_t     w_data
);

  // ------------------------------
  // write side
  // ------------------------------
  logic [$clog2(`PE_W_PAD_SIZE):0] wr_cnt;  // one bit over the address
  logic [$clog2(`PE_W_PAD_SIZE):0] w_total; // weights to accept
  logic                            w_push;

  data_t w_mem [`PE_W_PAD_SIZE];

  assign w_total = cfg.filter_len * cfg.filter_num;

  // counter stops at the total, so ready never comes back
  assign weights_loaded = (wr_cnt == w_total);
  assign weight_ready   = ~weights_loaded;
  assign w_push         = weight_valid & weight_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_cnt <= '0;
    end else if (w_push) begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (w_push) begin
      w_mem[waddr_t'(wr_cnt)] <= weight; // consecutive addresses
    end
  end

  // ------------------------------
  // read side
  // ------------------------------
  assign w_data = w_mem[w_addr]; // same-cycle read

endmodule

`default_nettype wire

/* verilog/pe_fmap_window.sv */
/* sliding pixel window, stride 1, prefetches up to PE_IF_PAD_SIZE pixels
   tap 0 is the oldest pixel held, slide drops exactly one pixel */
`default_nettype none

`include "pe_params.svh"

module pe_fmap_window import pe_pkg::*; (
  input  wire       clk,
  input  wire       rst,
  input  pe_cfg_t   cfg,
  // pixel stream
  input  wire       pix_valid,
  output logic      pix_ready,
  input  data_t     pix,
  output logic      window_full,
  // from the MAC engine
  input  wire       slide,
  input  faddr_t    tap,
  output data_t     px_data
);

  // ------------------------------
  // circular buffer state
  // ------------------------------
  faddr_t   wr_ptr; // next free slot
  faddr_t   head;   // oldest pixel
  tap_cnt_t count;  // pixels held, 0..8
  faddr_t   rd_idx;
  logic     push;

  data_t px_mem [`PE_IF_PAD_SIZE];

  assign pix_ready   = (count < tap_cnt_t'(`PE_IF_PAD_SIZE));
  assign push        = pix_valid & pix_ready;
  assign window_full = (count >= cfg.filter_len); // enough pixels for one window

  // pointers and occupancy
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      head   <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps at 8
      end
      if (slide) begin
        head <= head + 1'b1;     // drop oldest
      end
      // push and slide may coincide
      case ({push, slide})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // slot write
  always_ff @(posedge clk) begin
    if (push) begin
      px_mem[wr_ptr] <= pix;
    end
  end

  // ------------------------------
  // read port
  // ------------------------------
  // 3-bit add wraps modulo the window size
  assign rd_idx  = head + tap;
  assign px_data = px_mem[rd_idx];

endmodule

`default_nettype wire

/* verilog/pe_mac_engine.sv */
/* one dot product per filter, filter_len cycles each, then one cycle to load
   the output register; stalls in DRAIN while that register is still held */
`default_nettype none

`include "pe_params.svh"

module pe_mac_engine import pe_pkg::*; (
  input  wire       clk,
  input  wire       rst,
  input  pe_cfg_t   cfg,
  input  wire       weights_loaded,
  input  wire       window_full,
  // pad read ports
  output waddr_t    w_addr,
  input  data_t     w_data,
  output faddr_t    tap,
  input  data_t     px_data,
  output logic      slide,
  // psum stream
  output logic      psum_valid,
  input  wire       psum_ready,
  output pe_beat_t  psum_beat
);

  // ------------------------------
  // sequencer state
  // ------------------------------
  mac_state_t state;
  faddr_t     tap_q;    // current tap, 0..filter_len-1
  filt_idx_t  filt_q;   // current filter
  psum_t      acc;
  logic       last_tap;
  logic       last_filt;
  logic       load;     // sum moves into the output register

  logic signed [2*`PE_DATA_W-1:0] prod;

  // output register
  pe_beat_t beat_q;
  logic     out_valid_q;

  assign last_tap  = (tap_q == faddr_t'(cfg.filter_len - 1'b1));
  assign last_filt = (filt_q == cfg.filter_num - 1'b1);

  // register free, or emptied on this edge
  assign load  = (state == DRAIN) & (~out_valid_q | psum_ready);
  assign slide = load & last_filt; // window done

  // ------------------------------
  // pad addressing and MAC
  // ------------------------------
  assign w_addr = filt_q * cfg.filter_len + tap_q; // filter-major layout
  assign tap    = tap_q;
  assign prod   = w_data * px_data;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= IDLE;
      tap_q  <= '0;
      filt_q <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (weights_loaded && window_full) begin
            state <= ACCUM;
          end
        end
        ACCUM: begin
          if (last_tap) begin
            state <= DRAIN; // sum complete after this edge
          end else begin
            tap_q <= tap_q + 1'b1;
          end
        end
        DRAIN: begin
          if (load) begin
            tap_q <= '0;
            if (last_filt) begin
              filt_q <= '0;
              state  <= IDLE; // wait for the slid window
            end else begin
              filt_q <= filt_q + 1'b1;
              state  <= ACCUM;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // tap 0 restarts the sum, no separate clear
  always_ff @(posedge clk) begin
    if (state == ACCUM) begin
      acc <= ((tap_q == '0) ? psum_t'(0) : acc) + psum_t'(prod);
    end
  end

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid_q <= 1'b0;
    end else if (load) begin
      out_valid_q <= 1'b1; // new beat replaces any accepted one
    end else if (psum_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      beat_q.psum      <= acc;
      beat_q.filt      <= filt_q;
      beat_q.last_filt <= last_filt;
    end
  end

  assign psum_valid = out_valid_q;
  assign psum_beat  = beat_q;

endmodule

`default_nettype wire

/* verilog/pe_top.sv */
/* row-stationary 1-D conv PE, stride 1, valid/ready on all three streams
   cfg held stable from reset release to the end of the run */
`default_nettype none

module pe_top import pe_pkg::*; (
  input  wire       clk,
  input  wire       rst,
  input  pe_cfg_t   cfg,
  // weight stream
  input  wire       weight_valid,
  output logic      weight_ready,
  input  data_t     weight,
  // pixel stream
  input  wire       pix_valid,
  output logic      pix_ready,
  input  data_t     pix,
  // psum stream
  output logic      psum_valid,
  input  wire       psum_ready,
  output pe_beat_t  psum_beat
);

  // ------------------------------
  // internal wires
  // ------------------------------
  logic   weights_loaded;
  logic   window_full;
  logic   slide;     // engine done with a window
  waddr_t w_addr;
  data_t  w_data;
  faddr_t tap;       // offset from oldest pixel
  data_t  px_data;

  pe_weight_pad u_weight_pad (
    .clk            (clk),
    .rst            (rst),
    .cfg            (cfg),
    .weight_valid   (weight_valid),
    .weight_ready   (weight_ready),
    .weight         (weight),
    .weights_loaded (weights_loaded),
    .w_addr         (w_addr),
    .w_data         (w_data)
  );

  pe_fmap_window u_fmap_window (
    .clk         (clk),
    .rst         (rst),
    .cfg         (cfg),
    .pix_valid   (pix_valid),
    .pix_ready   (pix_ready),
    .pix         (pix),
    .window_full (window_full),
    .slide       (slide),
    .tap         (tap),
    .px_data     (px_data)
  );

  // sequencer and output stage
  pe_mac_engine u_mac_engine (
    .clk            (clk),
    .rst            (rst),
    .cfg            (cfg),
    .weights_loaded (weights_loaded),
    .window_full    (window_full),
    .w_addr         (w_addr),
    .w_data         (w_data),
    .tap            (tap),
    .px_data        (px_data),
    .slide          (slide),
    .psum_valid     (psum_valid),
    .psum_ready     (psum_ready),
    .psum_beat      (psum_beat)
  );

endmodule

`default_nettype wire

/* test/pe_sva.sv */
/* stream protocol checks, bound into every pe_top
   fail_cnt counts assertion failures for the testbench summary */
`default_nettype none

module pe_sva import pe_pkg::*; (
  input wire      clk,
  input wire      rst,
  input wire      weight_ready,
  input wire      psum_valid,
  input wire      psum_ready,
  input pe_beat_t psum_beat
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  // ------------------------------
  // psum stream
  // ------------------------------
  // stalled beat holds valid and data
  psum_hold: assert property (@(posedge clk) disable iff (rst)
    psum_valid && !psum_ready |=> psum_valid && $stable(psum_beat))
    else begin
      fail_cnt++;
      $error("psum beat changed or vanished under back-pressure");
    end

  // nothing to send right after reset release
  psum_quiet: assert property (@(posedge clk) $fell(rst) |-> !psum_valid)
    else begin
      fail_cnt++;
      $error("psum_valid high in the first cycle after reset");
    end

  // ------------------------------
  // weight stream
  // ------------------------------
  // weight pad loads once per reset
  weight_once: assert property (@(posedge clk) disable iff (rst)
    !weight_ready |=> !weight_ready)
    else begin
      fail_cnt++;
      $error("weight_ready came back after the pad was loaded");
    end

endmodule

bind pe_top pe_sva sva0 (
  .clk          (clk),
  .rst          (rst),
  .weight_ready (weight_ready),
  .psum_valid   (psum_valid),
  .psum_ready   (psum_ready),
  .psum_beat    (psum_beat)
);

`default_nettype wire

/* test/pe_tb.sv */
/* drives pe_top row by row from a stimulus table, random gaps and stalls
   stops at the first mismatch, expected beats come from a queue model */
`default_nettype none

`include "pe_params.svh"

module pe_tb import pe_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    int flen;      // taps per filter
    int fnum;      // filters
    int npix;      // pixels streamed
    int gap_pct;   // chance of an idle input cycle
    int stall_pct; // chance of psum_ready low
  } row_t;

  localparam int N_ROWS = 4;
  row_t rows [N_ROWS] = '{
    '{1, 1, 12, 20, 20},
    '{3, 4, 16, 30, 30},
    '{8, 8, 14, 10, 25},
    '{5, 2, 20, 50, 70}  // heavy stalls
  };

  logic     clk = 1'b0;
  logic     rst;
  pe_cfg_t  cfg;
  logic     weight_valid, weight_ready;
  data_t    weight;
  logic     pix_valid, pix_ready;
  data_t    pix;
  logic     psum_valid, psum_ready;
  pe_beat_t psum_beat;

  // model queues
  data_t     wq[$];
  data_t     pq[$];
  psum_t     exp_psum[$];
  filt_idx_t exp_filt[$];
  logic      exp_last[$];

  always #4 clk = ~clk; // 8 ns period

  pe_top dut0 (.*);

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic abort_run(input string msg);
    $display("FAIL %0t ns: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_psum(input psum_t got, input psum_t exp, input string what);
    if (got !== exp) abort_run($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  task automatic check_filt(input filt_idx_t got, input filt_idx_t exp, input string what);
    if (got !== exp) abort_run($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) abort_run($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  // ------------------------------
  // reference model
  // ------------------------------
  task automatic build_model(input row_t row);
    psum_t sum;
    wq.delete();
    pq.delete();
    for (int k = 0; k < row.flen * row.fnum; k++) wq.push_back(data_t'($urandom));
    for (int k = 0; k < row.npix; k++) pq.push_back(data_t'($urandom));
    // window n, filter f: sum of w[f*flen+i] * p[n+i]
    for (int n = 0; n <= row.npix - row.flen; n++) begin
      for (int f = 0; f < row.fnum; f++) begin
        sum = '0;
        for (int i = 0; i < row.flen; i++) begin
          sum += psum_t'(wq[f * row.flen + i]) * psum_t'(pq[n + i]);
        end
        exp_psum.push_back(sum);
        exp_filt.push_back(filt_idx_t'(f));
        exp_last.push_back(f == row.fnum - 1);
      end
    end
  endtask

  // ------------------------------
  // stream drivers, all on negedge
  // ------------------------------
  task automatic send_weights(input int gap_pct);
    int i;
    i = 0;
    repeat (`PE_IF_PAD_SIZE + 4) @(negedge clk); // pixels get ahead
    while (i < wq.size()) begin
      @(negedge clk);
      weight_valid = ($urandom_range(99) >= gap_pct);
      weight       = wq[i];
      if (weight_valid && weight_ready) i++; // taken at next posedge
    end
    // extra weights must be refused
    repeat (4) begin
      @(negedge clk);
      weight_valid = 1'b1;
      weight       = data_t'($urandom);
      check_flag(weight_ready, 1'b0, "weight_ready after full load");
    end
    @(negedge clk);
    weight_valid = 1'b0;
  endtask

  task automatic send_pixels(input int npix, input int gap_pct);
    int i;
    i = 0;
    while (i < npix) begin
      @(negedge clk);
      // no slide before the weights are in, window holds every pixel taken
      if (weight_ready) begin
        check_flag(pix_ready, i < `PE_IF_PAD_SIZE, "pix_ready before weights loaded");
      end
      pix_valid = ($urandom_range(99) >= gap_pct);
      pix       = pq[i];
      if (pix_valid && pix_ready) i++;
    end
    @(negedge clk);
    pix_valid = 1'b0;
  endtask

  task automatic collect_psums(input int n_beats, input int stall_pct, input int flen);
    int got;
    got = 0;
    while (got < n_beats) begin
      @(negedge clk);
      psum_ready = ($urandom_range(99) >= stall_pct);
      if (psum_valid && psum_ready) begin
        check_psum(psum_beat.psum, exp_psum.pop_front(), $sformatf("psum of beat %0d", got));
        check_filt(psum_beat.filt, exp_filt.pop_front(), $sformatf("filt of beat %0d", got));
        check_flag(psum_beat.last_filt, exp_last.pop_front(), "last_filt");
        got++;
      end
    end
    // no duplicate or stray beats afterwards
    repeat (4 * flen + 8) begin
      @(negedge clk);
      psum_ready = 1'b1;
      check_flag(psum_valid, 1'b0, "psum_valid after last beat");
    end
  endtask

  task automatic run_row(input row_t row);
    int n_beats;
    n_beats = row.fnum * (row.npix - row.flen + 1);
    @(negedge clk);
    rst            = 1'b1;
    cfg.filter_len = tap_cnt_t'(row.flen);
    cfg.filter_num = filt_idx_t'(row.fnum);
    weight_valid   = 1'b0;
    pix_valid      = 1'b0;
    psum_ready     = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    build_model(row);
    @(negedge clk);
    check_flag(psum_valid, 1'b0, "psum_valid after reset");
    check_flag(weight_ready, 1'b1, "weight_ready after reset");
    fork
      send_weights(row.gap_pct);
      send_pixels(row.npix, row.gap_pct);
      collect_psums(n_beats, row.stall_pct, row.flen);
    join
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin : main
    void'($urandom(71));
    rst          = 1'b1;
    cfg          = '0;
    weight_valid = 1'b0;
    weight       = '0;
    pix_valid    = 1'b0;
    pix          = '0;
    psum_ready   = 1'b0;
    for (int r = 0; r < N_ROWS; r++) run_row(rows[r]);
    if (dut0.sva0.fail_cnt == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("stream protocol assertions failed during the run");
    end
  end

  // bound protocol checker, stop on its first failure
  initial begin : assert_monitor
    wait (dut0.sva0.fail_cnt != 0);
    abort_run("a stream protocol assertion failed");
  end

  // limit from weights plus per-beat compute, x4 for stalls
  initial begin : watchdog
    longint unsigned budget;
    budget = 0;
    for (int k = 0; k < N_ROWS; k++) begin
      budget += rows[k].flen * rows[k].fnum
              + rows[k].npix * rows[k].fnum * (rows[k].flen + 2);
    end
    budget = budget * 4 * 8; // ns
    #(budget);
    $display("watchdog expired, the run made no progress before the time limit");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog");
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/pe_pkg.sv
verilog/pe_weight_pad.sv
verilog/pe_fmap_window.sv
verilog/pe_mac_engine.sv
verilog/pe_top.sv
test/pe_sva.sv
test/pe_tb.sv

/* Bender.yml */
package:
  name: pe_conv1d

sources:
  # RTL
  - include_dirs:
      - verilog
    files:
      - verilog/pe_pkg.sv
      - verilog/pe_weight_pad.sv
      - verilog/pe_fmap_window.sv
      - verilog/pe_mac_engine.sv
      - verilog/pe_top.sv
  # testbench and assertions
  - target: test
    include_dirs:
      - verilog
    files:
      - test/pe_sva.sv
      - test/pe_tb.sv
